// ==== Makefile ====
# Verilator build and run of the MIPS pipeline testbench.
# Run from the project root, where program.hex is read at time zero.

SOURCES = project.f $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

obj_dir/VmipsPipelineTb: $(SOURCES)
	verilator --binary -j 0 --timescale 1ns/1ns --top-module mipsPipelineTb -f project.f

run: obj_dir/VmipsPipelineTb
	./obj_dir/VmipsPipelineTb | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== bench/isaModel.svh ====
// Instruction-level model of the core: no delay slot, register zero fixed
// at zero, 64-word data memory. Included inside the testbench module.

localparam int maxModelSteps = 200;

typedef struct packed {
	wordT address;
	wordT data;
} storeT;

storeT expectedStores[$];
wordT  modelRom [memWords];
wordT  modelRam [memWords];
wordT  modelRegs [32];

// Runs the program one instruction at a time and queues every store.
// Stops at a beq that branches to itself
function automatic int runIsaModel();
	wordT    pc;
	wordT    nextPc;
	wordT    instr;
	wordT    a;
	wordT    b;
	wordT    imm;
	wordT    effAddr;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	int      steps;
	logic    halted;
	storeT   store;

	for (int i = 0; i < memWords; i++) begin
		modelRom[i] = '0;
		modelRam[i] = '0;
	end
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	$readmemh(programFile, modelRom);
	expectedStores.delete();

	pc     = '0;
	steps  = 0;
	halted = 1'b0;
	while (!halted && steps < maxModelSteps) begin
		// Past the end of the ROM the word is zero, which does nothing
		if ((pc >> (memAddrBits + 2)) == '0) begin
			instr = modelRom[pc[memAddrBits+1:2]];
		end else begin
			instr = '0;
		end
		rs      = instr[25:21];
		rt      = instr[20:16];
		rd      = instr[15:11];
		imm     = {{16{instr[15]}}, instr[15:0]};
		a       = modelRegs[rs];
		b       = modelRegs[rt];
		effAddr = a + imm;
		nextPc  = pc + 32'd4;

		case (instr[31:26])
			opRType: begin
				case (instr[5:0])
					functAdd: modelRegs[rd] = a + b;
					functSub: modelRegs[rd] = a - b;
					functAnd: modelRegs[rd] = a & b;
					functOr:  modelRegs[rd] = a | b;
					functSlt: modelRegs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:  ;
				endcase
			end
			opLw: modelRegs[rt] = modelRam[effAddr[memAddrBits+1:2]];
			opSw: begin
				store.address = effAddr;
				store.data    = b;
				expectedStores.push_back(store);
				modelRam[effAddr[memAddrBits+1:2]] = b;
			end
			opBeq: begin
				if (a == b) begin
					nextPc = pc + 32'd4 + (imm << 2);
				end
				if (nextPc == pc) begin
					halted = 1'b1;
				end
			end
			opAddi: modelRegs[rt] = a + imm;
			default: ;
		endcase

		modelRegs[0] = '0;
		pc = nextPc;
		steps++;
	end

	return expectedStores.size();
endfunction

// ==== bench/mipsPipelineTb.sv ====
// Testbench for the pipelined core. The store stream is checked against
// an instruction-level model of program.hex; run from the project root.
`timescale 1ns/1ns

module mipsPipelineTb import mipsPkg::*; ();

	localparam int resetCycles  = 16;
	localparam int storeTimeout = 2000;
	localparam int quietCycles  = 50;

	logic clk;
	logic reset;
	logic memWrite;
	wordT memAddress;
	wordT memWriteData;

	int seed = 31089;
	int errorCount;
	int storesSeen;
	int expectedCount;

	`include "isaModel.svh"

	mipsPipeline mipsPipeline_inst (
		.clk          (clk),
		.reset        (reset),
		.memWrite     (memWrite),
		.memAddress   (memAddress),
		.memWriteData (memWriteData)
	);

	always #10 clk = ~clk;

	// ************************************************************************
	// Store comparison
	// ************************************************************************
	task automatic checkStore(input wordT address, input wordT data);
		storeT expected;
		if (storesSeen >= expectedCount) begin
			$display("ERROR: extra store of %h to address %h at %0t ns",
				data, address, $time);
			errorCount++;
		end else begin
			expected = expectedStores[storesSeen];
			if (address !== expected.address) begin
				$display("MISMATCH store%0d address: expected %h, actual %h",
					storesSeen, expected.address, address);
				errorCount++;
			end
			if (data !== expected.data) begin
				$display("MISMATCH store%0d data: expected %h, actual %h",
					storesSeen, expected.data, data);
				errorCount++;
			end
		end
		storesSeen++;
	endtask

	// Outputs are registered, so the edge sees last cycle's values
	always @(posedge clk) begin
		if (memWrite !== 1'b0 && memWrite !== 1'b1) begin
			$display("ERROR: memWrite is unknown at %0t ns", $time);
			errorCount++;
		end else if (reset && memWrite) begin
			$display("ERROR: memWrite went high during reset at %0t ns", $time);
			errorCount++;
		end else if (memWrite) begin
			checkStore(memAddress, memWriteData);
		end
	end

	// ************************************************************************
	// Run control
	// ************************************************************************
	task automatic waitForStores();
		int cycles;
		cycles = 0;
		while (storesSeen < expectedCount && cycles < storeTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (storesSeen < expectedCount) begin
			$display("ERROR: timed out after %0d cycles, only %0d of %0d stores seen",
				cycles, storesSeen, expectedCount);
			errorCount++;
		end
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b0;
		errorCount = 0;
		storesSeen = 0;

		expectedCount = runIsaModel();
		$display("Model predicts %0d stores", expectedCount);
		if (expectedCount == 0) begin
			$display("ERROR: the model found no stores in the program");
			errorCount++;
		end

		#2;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#2;
		reset = 1'b0;

		waitForStores();
		// Anything stored from here on is an extra store
		repeat (quietCycles) @(negedge clk);

		$display("Stores seen %0d, expected %0d, errors %0d",
			storesSeen, expectedCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== design/controlDecoder.sv ====
// Main and ALU decode for the supported subset. Unknown opcode or funct
// gives an all-zero control word, so the instruction passes as a bubble.
`timescale 1ns/1ns

module controlDecoder import mipsPkg::*; (
	input  opcodeT  opcode,
	input  functT   funct,
	output controlT control
);

	always_comb begin
		control = '0;
		case (opcode)
			opRType: begin
				control.regWrite = 1'b1;
				control.regDst   = 1'b1;
				// ALU code comes straight from funct
				case (funct)
					functAdd: control.aluCode = aluAdd;
					functSub: control.aluCode = aluSub;
					functAnd: control.aluCode = aluAnd;
					functOr:  control.aluCode = aluOr;
					functSlt: control.aluCode = aluSlt;
					default:  control = '0;
				endcase
			end
			opLw: begin
				control.regWrite = 1'b1;
				control.memToReg = 1'b1;
				control.aluSrc   = 1'b1;
				control.aluCode  = aluAdd;
			end
			opSw: begin
				control.memWrite = 1'b1;
				control.aluSrc   = 1'b1;
				control.aluCode  = aluAdd;
			end
			opBeq: begin
				// Compared in decode, ALU result unused
				control.branch  = 1'b1;
				control.aluCode = aluSub;
			end
			opAddi: begin
				control.regWrite = 1'b1;
				control.aluSrc   = 1'b1;
				control.aluCode  = aluAdd;
			end
			default: begin
				control = '0;
			end
		endcase
	end

endmodule

// ==== design/decodeStage.sv ====
// Decode stage. beq resolves here with no delay slot; its operands take
// the memory-stage ALU result when the hazard unit selects it.
`timescale 1ns/1ns

module decodeStage import mipsPkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  fetchToDecodeT     fetchD,
	input  hazardT            hazard,
	input  wordT              aluOutM,
	input  memoryToWritebackT writebackW,
	input  wordT              resultW,
	output regAddrT           rsD,
	output regAddrT           rtD,
	output logic              branchD,
	output logic              pcSrc,
	output wordT              pcBranch,
	output decodeToExecuteT   decodeE
);

	controlT control;
	regAddrT rdD;
	wordT    signImm;
	wordT    rsData;
	wordT    rtData;
	wordT    compareA;
	wordT    compareB;

	// Instruction fields
	assign rsD     = fetchD.instr[25:21];
	assign rtD     = fetchD.instr[20:16];
	assign rdD     = fetchD.instr[15:11];
	assign signImm = {{16{fetchD.instr[15]}}, fetchD.instr[15:0]};

	controlDecoder controlDecoder_inst (
		.opcode  (fetchD.instr[31:26]),
		.funct   (fetchD.instr[5:0]),
		.control (control)
	);

	registerFile registerFile_inst (
		.clk         (clk),
		.reset       (reset),
		.readA       (rsD),
		.readB       (rtD),
		.writeEnable (writebackW.regWrite),
		.writeAddr   (writebackW.writeReg),
		.writeData   (resultW),
		.dataA       (rsData),
		.dataB       (rtData)
	);

	// ************************************************************************
	// Branch resolution
	// ************************************************************************
	assign compareA = hazard.forwardAD ? aluOutM : rsData;
	assign compareB = hazard.forwardBD ? aluOutM : rtData;
	assign branchD  = control.branch;
	assign pcSrc    = control.branch && (compareA == compareB);
	assign pcBranch = fetchD.pcPlus4 + {signImm[29:0], 2'b00};

	// Decode-to-execute register, flushed into a bubble on a stall
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			decodeE <= '0;
		end else if (hazard.flushE) begin
			decodeE <= '0;
		end else begin
			decodeE.regWrite <= control.regWrite;
			decodeE.memToReg <= control.memToReg;
			decodeE.memWrite <= control.memWrite;
			decodeE.aluSrc   <= control.aluSrc;
			decodeE.regDst   <= control.regDst;
			decodeE.aluCode  <= control.aluCode;
			decodeE.rsData   <= rsData;
			decodeE.rtData   <= rtData;
			decodeE.signImm  <= signImm;
			decodeE.rs       <= rsD;
			decodeE.rt       <= rtD;
			decodeE.rd       <= rdD;
		end
	end

endmodule

// ==== design/executeStage.sv ====
// Execute stage. Operands are forwarded from memory or writeback before
// the ALU; slt compares as signed.
`timescale 1ns/1ns

module executeStage import mipsPkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  decodeToExecuteT decodeE,
	input  hazardT          hazard,
	input  wordT            resultW,
	output executeToMemoryT memoryM
);

	wordT    srcA;
	wordT    writeData;
	wordT    srcB;
	wordT    aluOut;
	regAddrT writeReg;

	// Forwarding muxes
	always_comb begin
		case (hazard.forwardA)
			fwdWriteback: srcA = resultW;
			fwdMemory:    srcA = memoryM.aluOut;
			default:      srcA = decodeE.rsData;
		endcase
		case (hazard.forwardB)
			fwdWriteback: writeData = resultW;
			fwdMemory:    writeData = memoryM.aluOut;
			default:      writeData = decodeE.rtData;
		endcase
	end

	assign srcB = decodeE.aluSrc ? decodeE.signImm : writeData;

	always_comb begin
		case (decodeE.aluCode)
			aluAdd:  aluOut = srcA + srcB;
			aluSub:  aluOut = srcA - srcB;
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			default: aluOut = '0;
		endcase
	end

	assign writeReg = decodeE.regDst ? decodeE.rd : decodeE.rt;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			memoryM <= '0;
		end else begin
			memoryM.regWrite  <= decodeE.regWrite;
			memoryM.memToReg  <= decodeE.memToReg;
			memoryM.memWrite  <= decodeE.memWrite;
			memoryM.aluOut    <= aluOut;
			memoryM.writeData <= writeData;
			memoryM.writeReg  <= writeReg;
		end
	end

endmodule

// ==== design/hazardUnit.sv ====
// Combinational hazard detection. Any stall holds fetch and decode and
// turns the execute stage into a bubble for one cycle.
`timescale 1ns/1ns

module hazardUnit import mipsPkg::*; (
	input  regAddrT           rsD,
	input  regAddrT           rtD,
	input  logic              branchD,
	input  decodeToExecuteT   decodeE,
	input  executeToMemoryT   memoryM,
	input  memoryToWritebackT writebackW,
	output hazardT            hazard
);

	regAddrT writeRegE;
	logic    loadUseStall;
	logic    branchStall;

	assign writeRegE = decodeE.regDst ? decodeE.rd : decodeE.rt;

	// ************************************************************************
	// Forwarding
	// ************************************************************************
	always_comb begin
		hazard = '0;

		if (decodeE.rs != '0 && decodeE.rs == memoryM.writeReg && memoryM.regWrite)
			hazard.forwardA = fwdMemory;
		else if (decodeE.rs != '0 && decodeE.rs == writebackW.writeReg && writebackW.regWrite)
			hazard.forwardA = fwdWriteback;
		else
			hazard.forwardA = fwdRegFile;

		if (decodeE.rt != '0 && decodeE.rt == memoryM.writeReg && memoryM.regWrite)
			hazard.forwardB = fwdMemory;
		else if (decodeE.rt != '0 && decodeE.rt == writebackW.writeReg && writebackW.regWrite)
			hazard.forwardB = fwdWriteback;
		else
			hazard.forwardB = fwdRegFile;

		// Branch comparison only looks at memory
		hazard.forwardAD = (rsD != '0) && (rsD == memoryM.writeReg) && memoryM.regWrite;
		hazard.forwardBD = (rtD != '0) && (rtD == memoryM.writeReg) && memoryM.regWrite;

		hazard.stallF = loadUseStall || branchStall;
		hazard.stallD = loadUseStall || branchStall;
		hazard.flushE = loadUseStall || branchStall;
	end

	assign loadUseStall = decodeE.memToReg && (rsD == decodeE.rt || rtD == decodeE.rt);

	// Branch operand still in flight from execute, or a load in memory
	assign branchStall = branchD &&
		((decodeE.regWrite && (writeRegE == rsD || writeRegE == rtD)) ||
		(memoryM.memToReg && (memoryM.writeReg == rsD || memoryM.writeReg == rtD)));

endmodule

// ==== design/instructionFetch.sv ====
// Fetch stage. The ROM is loaded from the program file at time zero;
// any address beyond the loaded words reads as zero, which is a bubble.
`timescale 1ns/1ns

module instructionFetch import mipsPkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  hazardT        hazard,
	input  logic          pcSrc,
	input  wordT          pcBranch,
	output fetchToDecodeT fetchD
);

	wordT pc;
	wordT pcPlus4;
	wordT pcNext;
	wordT instr;
	wordT rom [memWords];

	initial begin
		for (int i = 0; i < memWords; i++) begin
			rom[i] = '0;
		end
		$readmemh(programFile, rom);
	end

	assign pcPlus4 = pc + 32'd4;
	assign pcNext  = pcSrc ? pcBranch : pcPlus4;

	// Upper PC bits outside the ROM give a bubble
	assign instr = (pc[31:memAddrBits+2] == '0) ? rom[pc[memAddrBits+1:2]] : '0;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!hazard.stallF) begin
			pc <= pcNext;
		end
	end

	// A taken branch squashes the wrong-path fetch, but only when not held
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			fetchD <= '0;
		end else if (!hazard.stallD) begin
			if (pcSrc) begin
				fetchD <= '0;
			end else begin
				fetchD.instr   <= instr;
				fetchD.pcPlus4 <= pcPlus4;
			end
		end
	end

endmodule

// ==== design/memoryStage.sv ====
// Memory and writeback. The data RAM is word addressed; the low two
// address bits and any bits above the RAM depth are ignored.
`timescale 1ns/1ns

module memoryStage import mipsPkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  executeToMemoryT   memoryM,
	output memoryToWritebackT writebackW,
	output wordT              resultW
);

	wordT                   ram [memWords];
	logic [memAddrBits-1:0] wordAddr;
	wordT                   readData;

	assign wordAddr = memoryM.aluOut[memAddrBits+1:2];
	assign readData = ram[wordAddr];

	// Store port
	always_ff @(posedge clk) begin
		if (memoryM.memWrite) begin
			ram[wordAddr] <= memoryM.writeData;
		end
	end

	// Memory-to-writeback register
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			writebackW <= '0;
		end else begin
			writebackW.regWrite <= memoryM.regWrite;
			writebackW.memToReg <= memoryM.memToReg;
			writebackW.readData <= readData;
			writebackW.aluOut   <= memoryM.aluOut;
			writebackW.writeReg <= memoryM.writeReg;
		end
	end

	// Writeback result, loads take the RAM word
	assign resultW = writebackW.memToReg ? writebackW.readData : writebackW.aluOut;

endmodule

// ==== design/mipsPipeline.sv ====
// Five-stage MIPS subset core. The only visible output is the store
// stream of the memory stage, valid while memWrite is high.
`timescale 1ns/1ns

module mipsPipeline import mipsPkg::*; (
	input  logic clk,
	input  logic reset,
	output logic memWrite,
	output wordT memAddress,
	output wordT memWriteData
);

	fetchToDecodeT     fetchD;
	decodeToExecuteT   decodeE;
	executeToMemoryT   memoryM;
	memoryToWritebackT writebackW;
	hazardT            hazard;
	wordT              resultW;
	wordT              pcBranch;
	logic              pcSrc;
	regAddrT           rsD;
	regAddrT           rtD;
	logic              branchD;

	instructionFetch instructionFetch_inst (
		.clk      (clk),
		.reset    (reset),
		.hazard   (hazard),
		.pcSrc    (pcSrc),
		.pcBranch (pcBranch),
		.fetchD   (fetchD)
	);

	decodeStage decodeStage_inst (
		.clk        (clk),
		.reset      (reset),
		.fetchD     (fetchD),
		.hazard     (hazard),
		.aluOutM    (memoryM.aluOut),
		.writebackW (writebackW),
		.resultW    (resultW),
		.rsD        (rsD),
		.rtD        (rtD),
		.branchD    (branchD),
		.pcSrc      (pcSrc),
		.pcBranch   (pcBranch),
		.decodeE    (decodeE)
	);

	executeStage executeStage_inst (
		.clk     (clk),
		.reset   (reset),
		.decodeE (decodeE),
		.hazard  (hazard),
		.resultW (resultW),
		.memoryM (memoryM)
	);

	memoryStage memoryStage_inst (
		.clk        (clk),
		.reset      (reset),
		.memoryM    (memoryM),
		.writebackW (writebackW),
		.resultW    (resultW)
	);

	hazardUnit hazardUnit_inst (
		.rsD        (rsD),
		.rtD        (rtD),
		.branchD    (branchD),
		.decodeE    (decodeE),
		.memoryM    (memoryM),
		.writebackW (writebackW),
		.hazard     (hazard)
	);

	assign memWrite     = memoryM.memWrite;
	assign memAddress   = memoryM.aluOut;
	assign memWriteData = memoryM.writeData;

endmodule

// ==== design/mipsPkg.sv ====
// Shared types and constants for the five-stage MIPS subset core.
// An all-zero control or pipeline word is a bubble that writes nothing.
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;
	typedef logic [2:0]  aluCodeT;
	typedef logic [1:0]  forwardSelT;

	// Opcodes
	localparam opcodeT opRType = 6'b000000;
	localparam opcodeT opLw    = 6'b100011;
	localparam opcodeT opSw    = 6'b101011;
	localparam opcodeT opBeq   = 6'b000100;
	localparam opcodeT opAddi  = 6'b001000;

	// R-type funct values
	localparam functT functAdd = 6'b100000;
	localparam functT functSub = 6'b100010;
	localparam functT functAnd = 6'b100100;
	localparam functT functOr  = 6'b100101;
	localparam functT functSlt = 6'b101010;

	// ALU operation codes
	localparam aluCodeT aluAdd = 3'b010;
	localparam aluCodeT aluSub = 3'b110;
	localparam aluCodeT aluAnd = 3'b000;
	localparam aluCodeT aluOr  = 3'b001;
	localparam aluCodeT aluSlt = 3'b111;

	// Execute operand sources
	localparam forwardSelT fwdRegFile   = 2'b00;
	localparam forwardSelT fwdWriteback = 2'b01;
	localparam forwardSelT fwdMemory    = 2'b10;

	// Depth of instruction ROM and data RAM, in words
	localparam int memWords    = 64;
	localparam int memAddrBits = $clog2(memWords);
	localparam string programFile = "program.hex";

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memWrite;
		logic    aluSrc;
		logic    regDst;
		logic    branch;
		aluCodeT aluCode;
	} controlT;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} fetchToDecodeT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memWrite;
		logic    aluSrc;
		logic    regDst;
		aluCodeT aluCode;
		wordT    rsData;
		wordT    rtData;
		wordT    signImm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
	} decodeToExecuteT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memWrite;
		wordT    aluOut;
		wordT    writeData;
		regAddrT writeReg;
	} executeToMemoryT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		wordT    readData;
		wordT    aluOut;
		regAddrT writeReg;
	} memoryToWritebackT;

	typedef struct packed {
		forwardSelT forwardA;
		forwardSelT forwardB;
		logic       forwardAD;
		logic       forwardBD;
		logic       stallF;
		logic       stallD;
		logic       flushE;
	} hazardT;

endpackage

// ==== design/registerFile.sv ====
// 32 x 32 register file, written on the rising edge. Register zero reads
// as zero; a read of the register being written returns the new value.
`timescale 1ns/1ns

module registerFile import mipsPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  regAddrT readA,
	input  regAddrT readB,
	input  logic    writeEnable,
	input  regAddrT writeAddr,
	input  wordT    writeData,
	output wordT    dataA,
	output wordT    dataB
);

	wordT regs [32];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle bypass replaces a half-cycle write
	assign dataA = (readA == '0) ? '0 :
		(writeEnable && writeAddr == readA) ? writeData : regs[readA];
	assign dataB = (readB == '0) ? '0 :
		(writeEnable && writeAddr == readB) ? writeData : regs[readB];

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line in hex, starting at byte address 0.
// Text after the word is the assembly for that word.
2001FFF7 // addi $1, $0, -9
20220013 // addi $2, $1, 19
00411822 // sub  $3, $2, $1
00622024 // and  $4, $3, $2
00622825 // or   $5, $3, $2
0025302A // slt  $6, $1, $5
AC060014 // sw   $6, 20($0)
AC010000 // sw   $1, 0($0)
AC020004 // sw   $2, 4($0)
AC030008 // sw   $3, 8($0)
AC04000C // sw   $4, 12($0)
AC050010 // sw   $5, 16($0)
8C070008 // lw   $7, 8($0)
00E54020 // add  $8, $7, $5
AC080018 // sw   $8, 24($0)
2009002E // addi $9, $0, 46
11280001 // beq  $9, $8, +1
AC09003C // sw   $9, 60($0)
210A0001 // addi $10, $8, 1
11480001 // beq  $10, $8, +1
AC0A001C // sw   $10, 28($0)
2000004D // addi $0, $0, 77
AC000020 // sw   $0, 32($0)
1000FFFF // beq  $0, $0, -1

// ==== project.f ====
+incdir+bench
design/mipsPkg.sv
design/registerFile.sv
design/controlDecoder.sv
design/instructionFetch.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/mipsPipeline.sv
bench/mipsPipelineTb.sv
